// File: Makefile
# Verilator build and run for the USB link monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_usbdev_link
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
src/usbdev_link_pkg.sv
src/usbdev_link_ev_if.sv
src/usbdev_us_timebase.sv
src/usbdev_line_filter.sv
src/usbdev_reset_det.sv
src/usbdev_idle_det.sv
src/usbdev_linkstate.sv
src/usbdev_link_top.sv
tb/tb_usbdev_link.sv

// File: src/usbdev_idle_det.sv
// Bus idle detector, raises the inactivity event after the suspend time while monitoring is on

`timescale 1ns/1ps

module usbdev_idle_det (
  input  logic          clk_48mhz_i,
  input  logic          rst_ni,
  input  logic          us_tick_i,
  input  logic          rx_idle_det_i,
  usbdev_link_ev_if.idle_det ev
);

  typedef enum logic [1:0] {
    InacActive,
    InacCount,
    InacPend
  } inac_state_e;

  inac_state_e inac_state_d, inac_state_q;
  logic [11:0] inac_timer_d, inac_timer_q;
  logic        stop_count;

  // Any non-idle symbol or monitoring turned off
  assign stop_count = ~rx_idle_det_i | ~ev.monitor_inac;

  always_comb begin
    inac_state_d       = inac_state_q;
    inac_timer_d       = inac_timer_q;
    ev.ev_bus_inactive = 1'b0;
    unique case (inac_state_q)
      // Bus busy or monitoring disabled
      InacActive: begin
        inac_timer_d = '0;
        if (!stop_count) begin
          inac_state_d = InacCount;
        end
      end
      // Idle line, time it
      InacCount: begin
        if (stop_count) begin
          inac_state_d = InacActive;
        end else if (us_tick_i) begin
          if (inac_timer_q == usbdev_link_pkg::SUSPEND_TIMEOUT_US) begin
            inac_state_d       = InacPend;
            ev.ev_bus_inactive = 1'b1;
          end else begin
            inac_timer_d = inac_timer_q + 12'd1;
          end
        end
      end
      // Event already sent, hold until activity
      InacPend: begin
        if (stop_count) begin
          inac_state_d = InacActive;
        end
      end
      default: inac_state_d = InacActive;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inac_state_q <= InacActive;
      inac_timer_q <= '0;
    end else begin
      inac_state_q <= inac_state_d;
      inac_timer_q <= inac_timer_d;
    end
  end

  inac_state_valid_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    inac_state_q inside {InacActive, InacCount, InacPend})
    else $error("Idle detector state illegal");

  // The state machine must have asked for inactivity timing
  inac_needs_monitor_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    ev.ev_bus_inactive |-> ev.monitor_inac)
    else $error("Bus inactive event without monitoring");

endmodule

// File: src/usbdev_line_filter.sv
// Glitch filter for line SE0 and VBUS sense, feeds the reset detector and link state machine

`timescale 1ns/1ps

module usbdev_line_filter (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  input  logic usb_dp_i,
  input  logic usb_dn_i,
  input  logic usb_oe_i,
  input  logic usb_sense_i,
  output logic see_se0_o,
  output logic see_pwr_sense_o
);

  // Bit 0 is SE0, bit 1 is VBUS sense
  logic [1:0] line_raw;
  logic [1:0] line_filt_q;
  logic [usbdev_link_pkg::FILTER_CYCLES-1:0] hist_q [2];

  // SE0 only counts while we are not driving the pins ourselves
  assign line_raw[0] = ~usb_dp_i & ~usb_dn_i & ~usb_oe_i;
  assign line_raw[1] = usb_sense_i;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2; i++) begin
        hist_q[i] <= '0;
      end
      line_filt_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // Newest sample enters at bit 0
        hist_q[i] <= {hist_q[i][usbdev_link_pkg::FILTER_CYCLES-2:0], line_raw[i]};
        // Output moves only once the whole history agrees
        if (&hist_q[i]) begin
          line_filt_q[i] <= 1'b1;
        end else if (~|hist_q[i]) begin
          line_filt_q[i] <= 1'b0;
        end
      end
    end
  end

  assign see_se0_o       = line_filt_q[0];
  assign see_pwr_sense_o = line_filt_q[1];

endmodule

// File: src/usbdev_link_ev_if.sv
// Event bundle between the reset and idle detectors and the link state machine

`timescale 1ns/1ps

interface usbdev_link_ev_if;

  // End of a valid bus reset, one cycle
  logic ev_reset;
  // Bus reset in progress
  logic link_reset;
  // Bus idle for the suspend time, one cycle
  logic ev_bus_inactive;
  // State machine wants inactivity timing
  logic monitor_inac;

  modport reset_det (
    output ev_reset,
    output link_reset
  );

  modport idle_det (
    output ev_bus_inactive,
    input  monitor_inac
  );

  modport fsm (
    input  ev_reset,
    input  link_reset,
    input  ev_bus_inactive,
    output monitor_inac
  );

endinterface

// File: src/usbdev_link_pkg.sv
// Timing constants and link state encoding shared by the link monitor RTL and its testbench

package usbdev_link_pkg;

  //////////////////////////////////////////////////
  // Timing constants
  //////////////////////////////////////////////////

  // Clock cycles per microsecond at 48 MHz
  localparam logic [5:0]  TICK_DIV           = 6'd48;
  // Equal samples needed before a filtered line changes
  localparam logic [2:0]  FILTER_CYCLES      = 3'd6;
  // SE0 longer than 2.5 us is a bus reset, 3 us keeps clear of resume EOP
  localparam logic [2:0]  RESET_TIMEOUT_US   = 3'd3;
  // Idle J for 3 ms means the host suspended the bus
  localparam logic [11:0] SUSPEND_TIMEOUT_US = 12'd3000;
  // One frame plus slack for host and device clock offset
  localparam logic [9:0]  SOF_TIMEOUT_US     = 10'd1005;
  // Missed frames in a row that count as a lost host
  localparam logic [2:0]  HOST_LOST_FRAMES   = 3'd4;

  //////////////////////////////////////////////////
  // Link states
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    // No VBUS or pull-up off
    LinkDisconnected     = 3'd0,
    // Attached but never reset
    LinkPowered          = 3'd1,
    LinkPoweredSuspended = 3'd2,
    // Reset seen, frames flowing
    LinkActive           = 3'd3,
    LinkSuspended        = 3'd4,
    LinkActiveNoSof      = 3'd5,
    LinkResuming         = 3'd6
  } link_state_e;

endpackage

// File: src/usbdev_link_top.sv
// Top level of the USB full-speed link monitor, wires timebase, filter, detectors and FSM

`timescale 1ns/1ps

module usbdev_link_top (
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  logic       usb_sense_i,
  input  logic       usb_dp_i,
  input  logic       usb_dn_i,
  input  logic       usb_oe_i,
  input  logic       usb_pullup_en_i,
  input  logic       rx_idle_det_i,
  input  logic       rx_j_det_i,
  input  logic       sof_detected_i,
  input  logic       resume_link_active_i,
  output logic       link_disconnect_o,
  output logic       link_powered_o,
  output logic       link_reset_o,
  output logic       link_active_o,
  output logic       link_suspend_o,
  output logic       link_resume_o,
  output logic       host_lost_o,
  output logic       sof_missed_o,
  output logic [2:0] link_state_o
);

  logic us_tick;
  logic see_se0;
  logic see_pwr_sense;

  // Detector events toward the state machine
  usbdev_link_ev_if link_ev ();

  usbdev_us_timebase u_timebase (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .us_tick_o   (us_tick)
  );

  usbdev_line_filter u_line_filter (
    .clk_48mhz_i     (clk_48mhz_i),
    .rst_ni          (rst_ni),
    .usb_dp_i        (usb_dp_i),
    .usb_dn_i        (usb_dn_i),
    .usb_oe_i        (usb_oe_i),
    .usb_sense_i     (usb_sense_i),
    .see_se0_o       (see_se0),
    .see_pwr_sense_o (see_pwr_sense)
  );

  usbdev_reset_det u_reset_det (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .us_tick_i   (us_tick),
    .see_se0_i   (see_se0),
    .ev          (link_ev.reset_det)
  );

  usbdev_idle_det u_idle_det (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .us_tick_i     (us_tick),
    .rx_idle_det_i (rx_idle_det_i),
    .ev            (link_ev.idle_det)
  );

  usbdev_linkstate u_linkstate (
    .clk_48mhz_i          (clk_48mhz_i),
    .rst_ni               (rst_ni),
    .us_tick_i            (us_tick),
    .see_pwr_sense_i      (see_pwr_sense),
    .usb_pullup_en_i      (usb_pullup_en_i),
    .rx_idle_det_i        (rx_idle_det_i),
    .rx_j_det_i           (rx_j_det_i),
    .sof_detected_i       (sof_detected_i),
    .resume_link_active_i (resume_link_active_i),
    .ev                   (link_ev.fsm),
    .link_disconnect_o    (link_disconnect_o),
    .link_powered_o       (link_powered_o),
    .link_reset_o         (link_reset_o),
    .link_active_o        (link_active_o),
    .link_suspend_o       (link_suspend_o),
    .link_resume_o        (link_resume_o),
    .host_lost_o          (host_lost_o),
    .sof_missed_o         (sof_missed_o),
    .link_state_o         (link_state_o)
  );

endmodule

// File: src/usbdev_linkstate.sv
// Link state machine with missed SOF and host loss supervision, driven by the detector events

`timescale 1ns/1ps

module usbdev_linkstate (
  input  logic                         clk_48mhz_i,
  input  logic                         rst_ni,
  input  logic                         us_tick_i,
  input  logic                         see_pwr_sense_i,
  input  logic                         usb_pullup_en_i,
  input  logic                         rx_idle_det_i,
  input  logic                         rx_j_det_i,
  input  logic                         sof_detected_i,
  input  logic                         resume_link_active_i,
  usbdev_link_ev_if.fsm                ev,
  output logic                         link_disconnect_o,
  output logic                         link_powered_o,
  output logic                         link_reset_o,
  output logic                         link_active_o,
  output logic                         link_suspend_o,
  output logic                         link_resume_o,
  output logic                         host_lost_o,
  output logic                         sof_missed_o,
  output usbdev_link_pkg::link_state_e link_state_o
);

  usbdev_link_pkg::link_state_e state_d, state_q;
  logic       ev_bus_active;
  logic [9:0] sof_timer_q;
  logic [2:0] miss_cnt_q;

  // Any non-idle symbol counts as bus activity
  assign ev_bus_active = ~rx_idle_det_i;

  assign link_state_o      = state_q;
  assign link_disconnect_o = (state_q == usbdev_link_pkg::LinkDisconnected);
  assign link_powered_o    = see_pwr_sense_i;
  assign link_reset_o      = ev.link_reset;
  assign link_active_o     = (state_q == usbdev_link_pkg::LinkActive) |
                             (state_q == usbdev_link_pkg::LinkActiveNoSof);
  assign link_suspend_o    = (state_q == usbdev_link_pkg::LinkSuspended) |
                             (state_q == usbdev_link_pkg::LinkPoweredSuspended);

  // Idle timing only matters where suspend can follow
  assign ev.monitor_inac = see_pwr_sense_i &
                           ((state_q == usbdev_link_pkg::LinkPowered) | link_active_o);

  always_comb begin
    state_d       = state_q;
    link_resume_o = 1'b0;
    // Lost VBUS or pull-up disabled overrides everything
    if (!see_pwr_sense_i || !usb_pullup_en_i) begin
      state_d = usbdev_link_pkg::LinkDisconnected;
    end else begin
      unique case (state_q)
        usbdev_link_pkg::LinkDisconnected: state_d = usbdev_link_pkg::LinkPowered;
        usbdev_link_pkg::LinkPowered: begin
          if (ev.ev_reset) begin
            state_d = usbdev_link_pkg::LinkActiveNoSof;
          end else if (resume_link_active_i) begin
            // Software resume after a power down of this block
            state_d = usbdev_link_pkg::LinkResuming;
          end else if (ev.ev_bus_inactive) begin
            state_d = usbdev_link_pkg::LinkPoweredSuspended;
          end
        end
        usbdev_link_pkg::LinkPoweredSuspended: begin
          if (ev.ev_reset) begin
            state_d = usbdev_link_pkg::LinkActiveNoSof;
          end else if (ev_bus_active) begin
            link_resume_o = 1'b1;
            state_d       = usbdev_link_pkg::LinkPowered;
          end
        end
        // Wait for J after resume signaling before timing frames
        usbdev_link_pkg::LinkResuming: begin
          if (rx_j_det_i || ev.ev_reset) begin
            link_resume_o = 1'b1;
            state_d       = usbdev_link_pkg::LinkActiveNoSof;
          end
        end
        usbdev_link_pkg::LinkActiveNoSof: begin
          if (ev.ev_bus_inactive) begin
            state_d = usbdev_link_pkg::LinkSuspended;
          end else if (sof_detected_i) begin
            state_d = usbdev_link_pkg::LinkActive;
          end
        end
        usbdev_link_pkg::LinkActive: begin
          if (ev.ev_bus_inactive) begin
            state_d = usbdev_link_pkg::LinkSuspended;
          end else if (ev.ev_reset) begin
            state_d = usbdev_link_pkg::LinkActiveNoSof;
          end
        end
        usbdev_link_pkg::LinkSuspended: begin
          if (ev.ev_reset) begin
            link_resume_o = 1'b1;
            state_d       = usbdev_link_pkg::LinkActiveNoSof;
          end else if (ev_bus_active) begin
            state_d = usbdev_link_pkg::LinkResuming;
          end
        end
        default: state_d = usbdev_link_pkg::LinkDisconnected;
      endcase
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= usbdev_link_pkg::LinkDisconnected;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // Missed SOF and host loss
  //////////////////////////////////////////////////

  assign sof_missed_o = (sof_timer_q == usbdev_link_pkg::SOF_TIMEOUT_US);
  assign host_lost_o  = (miss_cnt_q == usbdev_link_pkg::HOST_LOST_FRAMES);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sof_timer_q <= '0;
      miss_cnt_q  <= '0;
    end else begin
      // Frame timer restarts on every SOF or miss
      if (sof_missed_o || sof_detected_i || !link_active_o || ev.link_reset) begin
        sof_timer_q <= '0;
      end else if (us_tick_i) begin
        sof_timer_q <= sof_timer_q + 10'd1;
      end
      // Miss count saturates at the host lost limit
      if (sof_detected_i || !link_active_o || ev.link_reset) begin
        miss_cnt_q <= '0;
      end else if (sof_missed_o && !host_lost_o) begin
        miss_cnt_q <= miss_cnt_q + 3'd1;
      end
    end
  end

  link_state_valid_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    state_q inside {usbdev_link_pkg::LinkDisconnected, usbdev_link_pkg::LinkPowered,
                    usbdev_link_pkg::LinkPoweredSuspended, usbdev_link_pkg::LinkActive,
                    usbdev_link_pkg::LinkSuspended, usbdev_link_pkg::LinkActiveNoSof,
                    usbdev_link_pkg::LinkResuming})
    else $error("Link state illegal");

endmodule

// File: src/usbdev_reset_det.sv
// Bus reset detector, times filtered SE0 and reports reset level and end-of-reset event

`timescale 1ns/1ps

module usbdev_reset_det (
  input  logic           clk_48mhz_i,
  input  logic           rst_ni,
  input  logic           us_tick_i,
  input  logic           see_se0_i,
  usbdev_link_ev_if.reset_det ev
);

  typedef enum logic [1:0] {
    RstNone,
    RstCount,
    RstPend
  } rst_state_e;

  rst_state_e rst_state_d, rst_state_q;
  logic [2:0] rst_timer_d, rst_timer_q;

  always_comb begin
    rst_state_d = rst_state_q;
    rst_timer_d = rst_timer_q;
    unique case (rst_state_q)
      // Line not in SE0
      RstNone: begin
        if (see_se0_i) begin
          rst_state_d = RstCount;
          rst_timer_d = '0;
        end
      end
      // SE0 seen, count microseconds
      RstCount: begin
        if (!see_se0_i) begin
          rst_state_d = RstNone;
        end else if (us_tick_i) begin
          if (rst_timer_q == usbdev_link_pkg::RESET_TIMEOUT_US) begin
            rst_state_d = RstPend;
          end else begin
            rst_timer_d = rst_timer_q + 3'd1;
          end
        end
      end
      // Valid reset, wait for the line to leave SE0
      RstPend: begin
        if (!see_se0_i) begin
          rst_state_d = RstNone;
        end
      end
      default: rst_state_d = RstNone;
    endcase
  end

  // Reset level ends in the same cycle the event fires
  assign ev.link_reset = (rst_state_q == RstPend) & see_se0_i;
  assign ev.ev_reset   = (rst_state_q == RstPend) & ~see_se0_i;

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_state_q <= RstNone;
      rst_timer_q <= '0;
    end else begin
      rst_state_q <= rst_state_d;
      rst_timer_q <= rst_timer_d;
    end
  end

  rst_state_valid_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    rst_state_q inside {RstNone, RstCount, RstPend})
    else $error("Reset detector state illegal");

endmodule

// File: src/usbdev_us_timebase.sv
// Microsecond tick generator, one clock pulse per microsecond for all link timers

`timescale 1ns/1ps

module usbdev_us_timebase (
  input  logic clk_48mhz_i,
  input  logic rst_ni,
  output logic us_tick_o
);

  logic [5:0] div_cnt_q;
  logic       div_wrap;

  // Last cycle of each microsecond
  assign div_wrap = (div_cnt_q == usbdev_link_pkg::TICK_DIV - 6'd1);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
      us_tick_o <= 1'b0;
    end else begin
      div_cnt_q <= div_wrap ? 6'd0 : div_cnt_q + 6'd1;
      // Registered so the first tick lands 48 cycles after reset
      us_tick_o <= div_wrap;
    end
  end

  div_cnt_range_a: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    div_cnt_q <= usbdev_link_pkg::TICK_DIV - 6'd1)
    else $error("Timebase divider out of range");

endmodule

// File: tb/tb_usbdev_link.sv
// Directed testbench for the USB link monitor, run as top module with files.f under Verilator

`timescale 1ns/1ps

module tb_usbdev_link;

  // Wait lengths derived from the shared timing constants
  localparam int TICK      = int'(usbdev_link_pkg::TICK_DIV);
  localparam int SOF_US    = int'(usbdev_link_pkg::SOF_TIMEOUT_US);
  localparam int SUSP_US   = int'(usbdev_link_pkg::SUSPEND_TIMEOUT_US);
  localparam int LOST_CNT  = int'(usbdev_link_pkg::HOST_LOST_FRAMES);
  // Twenty suspend periods plus margin covers every test
  localparam int TIMEOUT_CYCLES = 20 * SUSP_US * TICK + 10000;

  logic clk_48mhz;
  logic rst_n;
  logic usb_sense, usb_dp, usb_dn, usb_oe, usb_pullup_en;
  logic rx_idle_det, rx_j_det, sof_detected, resume_link_active;
  logic link_disconnect, link_powered, link_reset, link_active;
  logic link_suspend, link_resume, host_lost, sof_missed;
  logic [2:0] link_state;
  int unsigned cycle_cnt;

  usbdev_link_top DUT (
    .clk_48mhz_i          (clk_48mhz),
    .rst_ni               (rst_n),
    .usb_sense_i          (usb_sense),
    .usb_dp_i             (usb_dp),
    .usb_dn_i             (usb_dn),
    .usb_oe_i             (usb_oe),
    .usb_pullup_en_i      (usb_pullup_en),
    .rx_idle_det_i        (rx_idle_det),
    .rx_j_det_i           (rx_j_det),
    .sof_detected_i       (sof_detected),
    .resume_link_active_i (resume_link_active),
    .link_disconnect_o    (link_disconnect),
    .link_powered_o       (link_powered),
    .link_reset_o         (link_reset),
    .link_active_o        (link_active),
    .link_suspend_o       (link_suspend),
    .link_resume_o        (link_resume),
    .host_lost_o          (host_lost),
    .sof_missed_o         (sof_missed),
    .link_state_o         (link_state)
  );

  // 4 ns period
  initial begin
    clk_48mhz = 1'b0;
    forever #2 clk_48mhz = ~clk_48mhz;
  end

  //////////////////////////////////////////////////
  // Reporting and watchdog
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on first error");
  endtask

  always @(posedge clk_48mhz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  task automatic expect_bit(string name, logic exp, logic act);
    assert (act === exp) else begin
      $display("FAILED t=%0t %s expected %0b got %0b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and sampling helpers
  //////////////////////////////////////////////////

  // Samples on falling edges, away from the driving edge
  task automatic wait_for_state(usbdev_link_pkg::link_state_e exp, int max_cycles,
                                string what, output int elapsed);
    logic found;
    found   = 1'b0;
    elapsed = 0;
    while (!found && elapsed < max_cycles) begin
      @(negedge clk_48mhz);
      elapsed++;
      found = (link_state == exp);
    end
    assert (found) else begin
      $display("ERROR: link state %0d not reached within %0d cycles %s",
               int'(exp), max_cycles, what);
      stop_on_error();
    end
  endtask

  task automatic catch_resume(int max_cycles, string what);
    logic found;
    found = 1'b0;
    for (int i = 0; i < max_cycles && !found; i++) begin
      @(negedge clk_48mhz);
      found = link_resume;
    end
    assert (found) else begin
      $display("ERROR: no link_resume_o pulse within %0d cycles %s", max_cycles, what);
      stop_on_error();
    end
  endtask

  task automatic wait_sof_miss(int max_cycles, output int elapsed);
    logic found;
    found   = 1'b0;
    elapsed = 0;
    while (!found && elapsed < max_cycles) begin
      @(negedge clk_48mhz);
      elapsed++;
      found = sof_missed;
    end
    assert (found) else begin
      $display("ERROR: no sof_missed_o pulse within %0d cycles", max_cycles);
      stop_on_error();
    end
  endtask

  // Drives SE0 for a number of cycles, notes the reset level seen meanwhile
  task automatic hold_se0(int cycles, output logic saw_reset, output logic reset_last);
    saw_reset  = 1'b0;
    reset_last = 1'b0;
    @(posedge clk_48mhz);
    usb_dp <= 1'b0;
    repeat (cycles) begin
      @(negedge clk_48mhz);
      saw_reset  = saw_reset | link_reset;
      reset_last = link_reset;
      @(posedge clk_48mhz);
    end
    usb_dp <= 1'b1;
  endtask

  // One-cycle strobe on SOF (0), J (1) or software resume (2)
  task automatic strobe_input(int which);
    @(posedge clk_48mhz);
    case (which)
      0: sof_detected <= 1'b1;
      1: rx_j_det <= 1'b1;
      default: resume_link_active <= 1'b1;
    endcase
    @(posedge clk_48mhz);
    sof_detected       <= 1'b0;
    rx_j_det           <= 1'b0;
    resume_link_active <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic power_cycle();
    int el;
    @(negedge clk_48mhz);
    expect_bit("link_disconnect_o", 1'b1, link_disconnect);
    expect_bit("link_powered_o", 1'b0, link_powered);
    expect_bit("link_reset_o", 1'b0, link_reset);
    expect_bit("link_active_o", 1'b0, link_active);
    expect_bit("link_suspend_o", 1'b0, link_suspend);
    expect_bit("link_resume_o", 1'b0, link_resume);
    expect_bit("host_lost_o", 1'b0, host_lost);
    expect_bit("sof_missed_o", 1'b0, sof_missed);
    @(posedge clk_48mhz);
    usb_sense <= 1'b1;
    wait_for_state(usbdev_link_pkg::LinkPowered, 20, "after sense rise", el);
    expect_bit("link_powered_o", 1'b1, link_powered);
    // Pull-up off detaches the device
    @(posedge clk_48mhz);
    usb_pullup_en <= 1'b0;
    wait_for_state(usbdev_link_pkg::LinkDisconnected, 4, "after pull-up off", el);
    expect_bit("link_disconnect_o", 1'b1, link_disconnect);
    @(posedge clk_48mhz);
    usb_pullup_en <= 1'b1;
    wait_for_state(usbdev_link_pkg::LinkPowered, 4, "after pull-up on", el);
  endtask

  task automatic bus_reset_seq();
    logic saw, last;
    int   el;
    // Short SE0 is not a reset
    hold_se0(TICK, saw, last);
    expect_bit("link_reset_o during 1 us SE0", 1'b0, saw);
    repeat (20) begin
      @(negedge clk_48mhz);
      expect_bit("link_state_o is LinkPowered", 1'b1,
                 link_state == usbdev_link_pkg::LinkPowered);
    end
    hold_se0(10 * TICK, saw, last);
    expect_bit("link_reset_o during 10 us SE0", 1'b1, last);
    wait_for_state(usbdev_link_pkg::LinkActiveNoSof, 20, "after SE0 release", el);
    expect_bit("link_reset_o", 1'b0, link_reset);
    expect_bit("link_active_o", 1'b1, link_active);
    strobe_input(0);
    wait_for_state(usbdev_link_pkg::LinkActive, 4, "after SOF", el);
  endtask

  task automatic sof_loss_seq();
    int el;
    // Traffic on the bus keeps suspend timing off
    @(posedge clk_48mhz);
    rx_idle_det <= 1'b0;
    for (int k = 0; k < LOST_CNT; k++) begin
      wait_sof_miss((SOF_US + 3) * TICK, el);
      expect_bit("sof_missed_o not early", 1'b1, el >= (SOF_US - 1) * TICK);
      @(negedge clk_48mhz);
      expect_bit("sof_missed_o one cycle", 1'b0, sof_missed);
      expect_bit("host_lost_o", k == LOST_CNT - 1, host_lost);
    end
    expect_bit("link_state_o is LinkActive", 1'b1,
               link_state == usbdev_link_pkg::LinkActive);
    strobe_input(0);
    @(negedge clk_48mhz);
    expect_bit("host_lost_o after SOF", 1'b0, host_lost);
  endtask

  task automatic suspend_resume_seq();
    int el;
    @(posedge clk_48mhz);
    rx_idle_det <= 1'b1;
    wait_for_state(usbdev_link_pkg::LinkSuspended, (SUSP_US + 3) * TICK, "on idle bus", el);
    expect_bit("suspend not early", 1'b1, el >= (SUSP_US - 1) * TICK);
    expect_bit("link_suspend_o", 1'b1, link_suspend);
    expect_bit("link_active_o", 1'b0, link_active);
    @(posedge clk_48mhz);
    rx_idle_det <= 1'b0;
    wait_for_state(usbdev_link_pkg::LinkResuming, 4, "after bus activity", el);
    // J ends resume signaling
    @(posedge clk_48mhz);
    rx_j_det <= 1'b1;
    catch_resume(4, "on J");
    @(posedge clk_48mhz);
    rx_j_det <= 1'b0;
    wait_for_state(usbdev_link_pkg::LinkActiveNoSof, 4, "after J", el);
  endtask

  task automatic powered_suspend_seq();
    logic saw, last;
    int   el;
    // Back to LinkPowered through a detach
    @(posedge clk_48mhz);
    usb_pullup_en <= 1'b0;
    wait_for_state(usbdev_link_pkg::LinkDisconnected, 4, "after pull-up off", el);
    @(posedge clk_48mhz);
    usb_pullup_en <= 1'b1;
    rx_idle_det   <= 1'b1;
    wait_for_state(usbdev_link_pkg::LinkPoweredSuspended, (SUSP_US + 6) * TICK,
                   "on idle bus while powered", el);
    expect_bit("link_suspend_o", 1'b1, link_suspend);
    @(posedge clk_48mhz);
    rx_idle_det <= 1'b0;
    catch_resume(4, "on activity in powered suspend");
    wait_for_state(usbdev_link_pkg::LinkPowered, 4, "after activity", el);
    strobe_input(2);
    wait_for_state(usbdev_link_pkg::LinkResuming, 4, "after software resume", el);
    hold_se0(10 * TICK, saw, last);
    expect_bit("link_reset_o during 10 us SE0", 1'b1, last);
    catch_resume(20, "on reset end while resuming");
    wait_for_state(usbdev_link_pkg::LinkActiveNoSof, 4, "after reset", el);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    cycle_cnt          <= 0;
    rst_n              <= 1'b0;
    usb_sense          <= 1'b0;
    usb_dp             <= 1'b1;
    usb_dn             <= 1'b0;
    usb_oe             <= 1'b0;
    usb_pullup_en      <= 1'b1;
    rx_idle_det        <= 1'b1;
    rx_j_det           <= 1'b0;
    sof_detected       <= 1'b0;
    resume_link_active <= 1'b0;
    repeat (16) @(posedge clk_48mhz);
    rst_n <= 1'b1;
    power_cycle();
    bus_reset_seq();
    sof_loss_seq();
    suspend_resume_seq();
    powered_suspend_seq();
    $display("PASS: all tests");
    $finish;
  end

endmodule
